/* src/rv_pkg.sv */
package rv_pkg;

  localparam int xlen = 32;
  localparam int reg_addr_w = 5;

  typedef logic [xlen-1:0] word_t;
  typedef logic [reg_addr_w-1:0] reg_idx_t;

  // major opcodes, insn[6:0]
  typedef enum logic [6:0] {
    op_load    = 7'b000_0011,
    op_store   = 7'b010_0011,
    op_branch  = 7'b110_0011,
    op_jalr    = 7'b110_0111,
    op_jal     = 7'b110_1111,
    op_reg_imm = 7'b001_0011,
    op_reg_reg = 7'b011_0011,
    op_system  = 7'b111_0011,
    op_auipc   = 7'b001_0111,
    op_lui     = 7'b011_0111
  } opcode_t;

  // alu funct3
  localparam logic [2:0] f3_add  = 3'b000;
  localparam logic [2:0] f3_sll  = 3'b001;
  localparam logic [2:0] f3_slt  = 3'b010;
  localparam logic [2:0] f3_sltu = 3'b011;
  localparam logic [2:0] f3_xor  = 3'b100;
  localparam logic [2:0] f3_sr   = 3'b101;
  localparam logic [2:0] f3_or   = 3'b110;
  localparam logic [2:0] f3_and  = 3'b111;

  // branch funct3
  localparam logic [2:0] f3_beq  = 3'b000;
  localparam logic [2:0] f3_bne  = 3'b001;
  localparam logic [2:0] f3_blt  = 3'b100;
  localparam logic [2:0] f3_bge  = 3'b101;
  localparam logic [2:0] f3_bltu = 3'b110;
  localparam logic [2:0] f3_bgeu = 3'b111;

  // load/store width funct3
  localparam logic [2:0] f3_byte   = 3'b000;
  localparam logic [2:0] f3_half   = 3'b001;
  localparam logic [2:0] f3_word   = 3'b010;
  localparam logic [2:0] f3_byte_u = 3'b100;
  localparam logic [2:0] f3_half_u = 3'b101;

  localparam logic [6:0] f7_base = 7'b000_0000;
  localparam logic [6:0] f7_alt  = 7'b010_0000;

  typedef enum logic [3:0] {
    alu_add, alu_sub, alu_sll, alu_slt, alu_sltu,
    alu_xor, alu_srl, alu_sra, alu_or, alu_and
  } alu_op_t;

  typedef enum logic [2:0] {
    wb_alu, wb_load, wb_pc_plus_4, wb_upper_imm, wb_pc_plus_imm
  } wb_sel_t;

  // width of the access comes from funct3
  typedef enum logic [1:0] {
    mem_none, mem_load, mem_store
  } mem_op_t;

  localparam int nop_pc_step = 4;

endpackage

/* src/rv_ctrl_if.sv */
`timescale 1ns/100ps

interface rv_ctrl_if;
  rv_pkg::alu_op_t alu_op;
  logic            use_imm;
  rv_pkg::wb_sel_t wb_sel;
  logic            reg_we;
  rv_pkg::mem_op_t mem_op;
  logic [2:0]      funct3;
  logic            is_branch;
  logic            is_jal;
  logic            is_jalr;
  rv_pkg::word_t   imm;
  rv_pkg::word_t   pc;
  rv_pkg::word_t   rs1_data;
  rv_pkg::word_t   rs2_data;
  logic            illegal;

  modport decode (
    output alu_op, use_imm, wb_sel, reg_we, mem_op, funct3,
    output is_branch, is_jal, is_jalr, imm, illegal
  );

  modport alu (input alu_op, use_imm, funct3, is_branch, imm, rs1_data, rs2_data);

  modport lsu (input mem_op, funct3, imm, rs1_data, rs2_data);

  modport fetch (input is_jal, is_jalr, imm, rs1_data);

endinterface

/* src/rv_decode.sv */
`timescale 1ns/100ps

module rv_decode (
  input  rv_pkg::word_t    insn,
  rv_ctrl_if.decode        ctrl,
  output rv_pkg::reg_idx_t rs1,
  output rv_pkg::reg_idx_t rs2,
  output rv_pkg::reg_idx_t rd
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  rv_pkg::word_t imm_i;
  rv_pkg::word_t imm_s;
  rv_pkg::word_t imm_b;
  rv_pkg::word_t imm_j;
  rv_pkg::word_t imm_u;
  logic f7_ok;

  assign opcode = insn[6:0];
  assign funct3 = insn[14:12];
  assign funct7 = insn[31:25];
  assign rd     = insn[11:7];
  assign rs1    = insn[19:15];
  assign rs2    = insn[24:20];

  assign imm_i = {{20{insn[31]}}, insn[31:20]};
  assign imm_s = {{20{insn[31]}}, insn[31:25], insn[11:7]};
  assign imm_b = {{19{insn[31]}}, insn[31], insn[7], insn[30:25], insn[11:8], 1'b0};
  assign imm_j = {{11{insn[31]}}, insn[31], insn[19:12], insn[20], insn[30:21], 1'b0};
  assign imm_u = {insn[31:12], 12'd0};

  // only add/sub and srl/sra have an alternate funct7
  assign f7_ok = (funct7 == rv_pkg::f7_base) ||
                 (funct7 == rv_pkg::f7_alt && (funct3 == rv_pkg::f3_add ||
                                               funct3 == rv_pkg::f3_sr));

  always_comb begin
    ctrl.alu_op    = rv_pkg::alu_add;
    ctrl.use_imm   = 1'b0;
    ctrl.wb_sel    = rv_pkg::wb_alu;
    ctrl.reg_we    = 1'b0;
    ctrl.mem_op    = rv_pkg::mem_none;
    ctrl.funct3    = funct3;
    ctrl.is_branch = 1'b0;
    ctrl.is_jal    = 1'b0;
    ctrl.is_jalr   = 1'b0;
    ctrl.imm       = imm_i;
    ctrl.illegal   = 1'b0;

    // operation from funct3, funct7 only matters for shifts and reg-reg add
    case (funct3)
      rv_pkg::f3_add: begin
        if (opcode == rv_pkg::op_reg_reg && funct7 == rv_pkg::f7_alt) begin
          ctrl.alu_op = rv_pkg::alu_sub;
        end
      end
      rv_pkg::f3_sll:  ctrl.alu_op = rv_pkg::alu_sll;
      rv_pkg::f3_slt:  ctrl.alu_op = rv_pkg::alu_slt;
      rv_pkg::f3_sltu: ctrl.alu_op = rv_pkg::alu_sltu;
      rv_pkg::f3_xor:  ctrl.alu_op = rv_pkg::alu_xor;
      rv_pkg::f3_sr: begin
        ctrl.alu_op = (funct7 == rv_pkg::f7_alt) ? rv_pkg::alu_sra : rv_pkg::alu_srl;
      end
      rv_pkg::f3_or:   ctrl.alu_op = rv_pkg::alu_or;
      default:         ctrl.alu_op = rv_pkg::alu_and;
    endcase

    case (opcode)
      rv_pkg::op_lui: begin
        ctrl.imm    = imm_u;
        ctrl.wb_sel = rv_pkg::wb_upper_imm;
        ctrl.reg_we = 1'b1;
      end
      rv_pkg::op_auipc: begin
        ctrl.imm    = imm_u;
        ctrl.wb_sel = rv_pkg::wb_pc_plus_imm;
        ctrl.reg_we = 1'b1;
      end
      rv_pkg::op_jal: begin
        ctrl.imm    = imm_j;
        ctrl.is_jal = 1'b1;
        ctrl.wb_sel = rv_pkg::wb_pc_plus_4;
        ctrl.reg_we = 1'b1;
      end
      rv_pkg::op_jalr: begin
        ctrl.is_jalr = 1'b1;
        ctrl.wb_sel  = rv_pkg::wb_pc_plus_4;
        ctrl.reg_we  = 1'b1;
        ctrl.illegal = (funct3 != 3'b000);
      end
      rv_pkg::op_branch: begin
        ctrl.imm       = imm_b;
        ctrl.is_branch = 1'b1;
        ctrl.illegal   = (funct3 == 3'b010 || funct3 == 3'b011);
      end
      rv_pkg::op_load: begin
        ctrl.mem_op  = rv_pkg::mem_load;
        ctrl.wb_sel  = rv_pkg::wb_load;
        ctrl.reg_we  = 1'b1;
        ctrl.illegal = !(funct3 inside {rv_pkg::f3_byte, rv_pkg::f3_half, rv_pkg::f3_word,
                                        rv_pkg::f3_byte_u, rv_pkg::f3_half_u});
      end
      rv_pkg::op_store: begin
        ctrl.imm     = imm_s;
        ctrl.mem_op  = rv_pkg::mem_store;
        ctrl.illegal = !(funct3 inside {rv_pkg::f3_byte, rv_pkg::f3_half, rv_pkg::f3_word});
      end
      rv_pkg::op_reg_imm: begin
        ctrl.use_imm = 1'b1;
        ctrl.reg_we  = 1'b1;
        // shamt encodings reuse funct7
        if (funct3 == rv_pkg::f3_sll || funct3 == rv_pkg::f3_sr) begin
          ctrl.illegal = !f7_ok;
        end
      end
      rv_pkg::op_reg_reg: begin
        ctrl.reg_we  = 1'b1;
        ctrl.illegal = !f7_ok;
      end
      rv_pkg::op_system: begin
        // ecall only, no architectural effect besides halt
        ctrl.illegal = (insn[31:7] != 25'd0);
      end
      default: ctrl.illegal = 1'b1;
    endcase

    // illegal executes as a nop
    if (ctrl.illegal) begin
      ctrl.reg_we    = 1'b0;
      ctrl.mem_op    = rv_pkg::mem_none;
      ctrl.is_branch = 1'b0;
      ctrl.is_jal    = 1'b0;
      ctrl.is_jalr   = 1'b0;
    end
  end

endmodule

/* src/rv_regfile.sv */
`timescale 1ns/100ps

module rv_regfile (
  input  logic             clk,
  input  logic             rst,
  input  rv_pkg::reg_idx_t rs1,
  input  rv_pkg::reg_idx_t rs2,
  input  rv_pkg::reg_idx_t rd,
  input  logic             we,
  input  rv_pkg::word_t    rd_data,
  output rv_pkg::word_t    rs1_data,
  output rv_pkg::word_t    rs2_data
);

  // x0 has no storage
  rv_pkg::word_t regs [1:31];

  assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
  assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (we && rd != '0) begin
      regs[rd] <= rd_data;
    end
  end

endmodule

/* src/rv_alu.sv */
`timescale 1ns/100ps

module rv_alu (
  rv_ctrl_if.alu        ctrl,
  output rv_pkg::word_t result,
  output logic          branch_taken
);

  rv_pkg::word_t op_a;
  rv_pkg::word_t op_b;
  logic [4:0] shamt;

  assign op_a  = ctrl.rs1_data;
  assign op_b  = ctrl.use_imm ? ctrl.imm : ctrl.rs2_data;
  assign shamt = op_b[4:0];

  always_comb begin
    case (ctrl.alu_op)
      rv_pkg::alu_add:  result = op_a + op_b;
      rv_pkg::alu_sub:  result = op_a - op_b;
      rv_pkg::alu_sll:  result = op_a << shamt;
      rv_pkg::alu_slt:  result = {31'd0, $signed(op_a) < $signed(op_b)};
      rv_pkg::alu_sltu: result = {31'd0, op_a < op_b};
      rv_pkg::alu_xor:  result = op_a ^ op_b;
      rv_pkg::alu_srl:  result = op_a >> shamt;
      rv_pkg::alu_sra:  result = $signed(op_a) >>> shamt;
      rv_pkg::alu_or:   result = op_a | op_b;
      default:          result = op_a & op_b;
    endcase
  end

  // branches always compare the two registers
  always_comb begin
    branch_taken = 1'b0;
    if (ctrl.is_branch) begin
      case (ctrl.funct3)
        rv_pkg::f3_beq:  branch_taken = (ctrl.rs1_data == ctrl.rs2_data);
        rv_pkg::f3_bne:  branch_taken = (ctrl.rs1_data != ctrl.rs2_data);
        rv_pkg::f3_blt:  branch_taken = ($signed(ctrl.rs1_data) < $signed(ctrl.rs2_data));
        rv_pkg::f3_bge:  branch_taken = ($signed(ctrl.rs1_data) >= $signed(ctrl.rs2_data));
        rv_pkg::f3_bltu: branch_taken = (ctrl.rs1_data < ctrl.rs2_data);
        rv_pkg::f3_bgeu: branch_taken = (ctrl.rs1_data >= ctrl.rs2_data);
        default:         branch_taken = 1'b0;
      endcase
    end
  end

  always_comb begin
    assert (!branch_taken || ctrl.is_branch);
  end

endmodule

/* src/rv_lsu.sv */
`timescale 1ns/100ps

module rv_lsu (
  rv_ctrl_if.lsu        ctrl,
  input  rv_pkg::word_t load_data,
  output rv_pkg::word_t addr,
  output rv_pkg::word_t store_data,
  output logic [3:0]    store_we,
  output rv_pkg::word_t load_result,
  output logic          misaligned
);

  rv_pkg::word_t eff_addr;
  rv_pkg::word_t lane;
  logic [4:0]    lane_shift;

  assign eff_addr   = ctrl.rs1_data + ctrl.imm;
  assign addr       = {eff_addr[31:2], 2'b00};
  assign lane_shift = {eff_addr[1:0], 3'b000};

  // funct3[1:0] gives the access size for both loads and stores
  always_comb begin
    misaligned = 1'b0;
    if (ctrl.mem_op != rv_pkg::mem_none) begin
      case (ctrl.funct3[1:0])
        2'b01:   misaligned = eff_addr[0];
        2'b10:   misaligned = (eff_addr[1:0] != 2'b00);
        default: misaligned = 1'b0;
      endcase
    end
  end

  // low bytes of rs2 shifted up to the addressed lane
  assign store_data = ctrl.rs2_data << lane_shift;

  always_comb begin
    store_we = 4'b0000;
    if (ctrl.mem_op == rv_pkg::mem_store && !misaligned) begin
      case (ctrl.funct3[1:0])
        2'b00:   store_we = 4'b0001 << eff_addr[1:0];
        2'b01:   store_we = eff_addr[1] ? 4'b1100 : 4'b0011;
        default: store_we = 4'b1111;
      endcase
    end
  end

  assign lane = load_data >> lane_shift;

  always_comb begin
    case (ctrl.funct3)
      rv_pkg::f3_byte:   load_result = {{24{lane[7]}}, lane[7:0]};
      rv_pkg::f3_half:   load_result = {{16{lane[15]}}, lane[15:0]};
      rv_pkg::f3_byte_u: load_result = {24'd0, lane[7:0]};
      rv_pkg::f3_half_u: load_result = {16'd0, lane[15:0]};
      default:           load_result = lane;
    endcase
  end

  always_comb begin
    assert (store_we inside {4'b0000, 4'b0001, 4'b0010, 4'b0100, 4'b1000,
                             4'b0011, 4'b1100, 4'b1111});
  end

endmodule

/* src/rv_fetch.sv */
`timescale 1ns/100ps

module rv_fetch (
  input  logic          clk,
  input  logic          rst,
  rv_ctrl_if.fetch      ctrl,
  input  logic          branch_taken,
  output rv_pkg::word_t pc
);

  rv_pkg::word_t pc_next;
  rv_pkg::word_t jalr_target;

  assign jalr_target = ctrl.rs1_data + ctrl.imm;

  always_comb begin
    if (ctrl.is_jalr) begin
      pc_next = {jalr_target[31:1], 1'b0};
    end else if (branch_taken || ctrl.is_jal) begin
      pc_next = pc + ctrl.imm;
    end else begin
      pc_next = pc + rv_pkg::nop_pc_step;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      pc <= '0;
    end else begin
      pc <= pc_next;
    end
  end

  // branch and jal offsets are even, jalr target is forced even
  assert property (@(posedge clk) disable iff (rst) pc[0] == 1'b0);

endmodule

/* src/rv_core.sv */
`timescale 1ns/100ps

module rv_core (
  input  logic          clk,
  input  logic          rst,
  input  rv_pkg::word_t insn_from_imem,
  input  rv_pkg::word_t load_data_from_dmem,
  output rv_pkg::word_t pc_to_imem,
  output rv_pkg::word_t addr_to_dmem,
  output rv_pkg::word_t store_data_to_dmem,
  output logic [3:0]    store_we_to_dmem,
  output logic          halt
);

  rv_pkg::reg_idx_t rs1;
  rv_pkg::reg_idx_t rs2;
  rv_pkg::reg_idx_t rd;
  rv_pkg::word_t    rs1_data;
  rv_pkg::word_t    rs2_data;
  rv_pkg::word_t    rd_data;
  rv_pkg::word_t    alu_result;
  rv_pkg::word_t    load_result;
  logic [3:0]       lsu_store_we;
  logic             branch_taken;
  logic             misaligned;
  logic             rf_we;

  rv_ctrl_if ctrl ();

  assign ctrl.pc       = pc_to_imem;
  assign ctrl.rs1_data = rs1_data;
  assign ctrl.rs2_data = rs2_data;

  rv_decode u_decode (
    .insn (insn_from_imem),
    .ctrl (ctrl),
    .rs1  (rs1),
    .rs2  (rs2),
    .rd   (rd)
  );

  rv_regfile u_regfile (
    .clk      (clk),
    .rst      (rst),
    .rs1      (rs1),
    .rs2      (rs2),
    .rd       (rd),
    .we       (rf_we),
    .rd_data  (rd_data),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data)
  );

  rv_alu u_alu (
    .ctrl         (ctrl),
    .result       (alu_result),
    .branch_taken (branch_taken)
  );

  rv_lsu u_lsu (
    .ctrl        (ctrl),
    .load_data   (load_data_from_dmem),
    .addr        (addr_to_dmem),
    .store_data  (store_data_to_dmem),
    .store_we    (lsu_store_we),
    .load_result (load_result),
    .misaligned  (misaligned)
  );

  rv_fetch u_fetch (
    .clk          (clk),
    .rst          (rst),
    .ctrl         (ctrl),
    .branch_taken (branch_taken),
    .pc           (pc_to_imem)
  );

  always_comb begin
    case (ctrl.wb_sel)
      rv_pkg::wb_load:        rd_data = load_result;
      rv_pkg::wb_pc_plus_4:   rd_data = ctrl.pc + rv_pkg::nop_pc_step;
      rv_pkg::wb_upper_imm:   rd_data = ctrl.imm;
      rv_pkg::wb_pc_plus_imm: rd_data = ctrl.pc + ctrl.imm;
      default:                rd_data = alu_result;
    endcase
  end

  // misaligned load leaves rd untouched
  assign rf_we = ctrl.reg_we && !misaligned;

  // instruction word is ignored while in reset
  assign store_we_to_dmem = rst ? 4'b0000 : lsu_store_we;
  assign halt = !rst && (insn_from_imem == {25'd0, rv_pkg::op_system});

  // an illegal insn must behave as a nop across decode, lsu and fetch
  assert property (@(posedge clk) disable iff (rst)
    ctrl.illegal |-> (!rf_we && store_we_to_dmem == 4'b0000) ##1
      (pc_to_imem == $past(pc_to_imem) + rv_pkg::nop_pc_step));

endmodule

/* dv/tb_clock.sv */
`timescale 1ns/100ps

module tb_clock #(
  parameter int period_ns    = 10,
  parameter int reset_cycles = 3
) (
  output logic clk,
  output logic rst
);

  initial begin
    clk = 1'b0;
    forever #(period_ns / 2) clk = ~clk;
  end

  // release a little after the last reset edge
  initial begin
    rst = 1'b1;
    repeat (reset_cycles) @(posedge clk);
    #1;
    rst = 1'b0;
  end

endmodule

/* dv/tb_checker.sv */
`timescale 1ns/100ps

module tb_checker (
  input  logic          clk,
  input  logic          rst,
  input  rv_pkg::word_t insn,
  input  rv_pkg::word_t load_data,
  input  rv_pkg::word_t pc,
  input  rv_pkg::word_t addr,
  input  rv_pkg::word_t store_data,
  input  logic [3:0]    store_we,
  input  logic          halt,
  output int            error_count,
  output int            check_count
);

  rv_pkg::word_t regs [32];
  rv_pkg::word_t model_pc;

  task automatic check_value(input string name, input rv_pkg::word_t expected,
                             input rv_pkg::word_t actual);
    check_count++;
    if (actual !== expected) begin
      error_count++;
      $display("ERROR %0t: %s expected %h, got %h", $time, name, expected, actual);
    end
  endtask

  function automatic rv_pkg::word_t alu_model(input logic [2:0] f3, input logic alt,
                                              input rv_pkg::word_t x, input rv_pkg::word_t y);
    rv_pkg::word_t res;
    logic [4:0]    sh;
    sh = y[4:0];
    case (f3)
      rv_pkg::f3_add:  res = alt ? x - y : x + y;
      rv_pkg::f3_sll:  res = x << sh;
      rv_pkg::f3_slt:  res = ($signed(x) < $signed(y)) ? 32'd1 : 32'd0;
      rv_pkg::f3_sltu: res = (x < y) ? 32'd1 : 32'd0;
      rv_pkg::f3_xor:  res = x ^ y;
      rv_pkg::f3_sr: begin
        if (alt) begin
          res = $signed(x) >>> sh;
        end else begin
          res = x >> sh;
        end
      end
      rv_pkg::f3_or:   res = x | y;
      default:         res = x & y;
    endcase
    return res;
  endfunction

  // compare this cycle's outputs, then retire the instruction into the model
  task automatic execute_and_compare();
    logic [2:0]    f3;
    logic [4:0]    rd;
    logic          write_rd;
    logic          taken;
    logic          mis;
    logic [3:0]    exp_we;
    logic [7:0]    lane8;
    logic [15:0]   lane16;
    rv_pkg::word_t a;
    rv_pkg::word_t b;
    rv_pkg::word_t imm_i;
    rv_pkg::word_t imm_s;
    rv_pkg::word_t imm_b;
    rv_pkg::word_t imm_j;
    rv_pkg::word_t imm_u;
    rv_pkg::word_t ea;
    rv_pkg::word_t result;
    rv_pkg::word_t next_pc;
    rv_pkg::word_t exp_data;
    rv_pkg::word_t mask;
    f3 = insn[14:12];
    rd = insn[11:7];
    a = regs[insn[19:15]];
    b = regs[insn[24:20]];
    imm_i = {{20{insn[31]}}, insn[31:20]};
    imm_s = {{20{insn[31]}}, insn[31:25], insn[11:7]};
    imm_b = {{20{insn[31]}}, insn[7], insn[30:25], insn[11:8], 1'b0};
    imm_j = {{12{insn[31]}}, insn[19:12], insn[20], insn[30:21], 1'b0};
    imm_u = {insn[31:12], 12'd0};
    next_pc = model_pc + 32'd4;
    write_rd = 1'b0;
    result = '0;
    exp_we = 4'b0000;
    exp_data = '0;
    ea = '0;
    check_value("pc_to_imem", model_pc, pc);
    check_value("halt", {31'd0, insn == 32'h0000_0073}, {31'd0, halt});
    case (insn[6:0])
      rv_pkg::op_lui: begin
        result = imm_u;
        write_rd = 1'b1;
      end
      rv_pkg::op_auipc: begin
        result = model_pc + imm_u;
        write_rd = 1'b1;
      end
      rv_pkg::op_jal: begin
        result = model_pc + 32'd4;
        write_rd = 1'b1;
        next_pc = model_pc + imm_j;
      end
      rv_pkg::op_jalr: begin
        result = model_pc + 32'd4;
        write_rd = 1'b1;
        next_pc = (a + imm_i) & ~32'd1;
      end
      rv_pkg::op_branch: begin
        case (f3)
          rv_pkg::f3_beq:  taken = (a == b);
          rv_pkg::f3_bne:  taken = (a != b);
          rv_pkg::f3_blt:  taken = ($signed(a) < $signed(b));
          rv_pkg::f3_bge:  taken = ($signed(a) >= $signed(b));
          rv_pkg::f3_bltu: taken = (a < b);
          default:         taken = (a >= b);
        endcase
        if (taken) begin
          next_pc = model_pc + imm_b;
        end
      end
      rv_pkg::op_load: begin
        ea = a + imm_i;
        mis = (f3[1:0] == 2'b01 && ea[0]) || (f3[1:0] == 2'b10 && ea[1:0] != 2'b00);
        lane8 = load_data[{ea[1:0], 3'b000} +: 8];
        lane16 = load_data[{ea[1], 4'b0000} +: 16];
        case (f3)
          rv_pkg::f3_byte:   result = {{24{lane8[7]}}, lane8};
          rv_pkg::f3_half:   result = {{16{lane16[15]}}, lane16};
          rv_pkg::f3_byte_u: result = {24'd0, lane8};
          rv_pkg::f3_half_u: result = {16'd0, lane16};
          default:           result = load_data;
        endcase
        write_rd = !mis;
      end
      rv_pkg::op_store: begin
        ea = a + imm_s;
        mis = (f3[1:0] == 2'b01 && ea[0]) || (f3[1:0] == 2'b10 && ea[1:0] != 2'b00);
        // replicated data, so any enabled lane holds the right bytes
        case (f3[1:0])
          2'b00: begin
            case (ea[1:0])
              2'b00:   exp_we = 4'b0001;
              2'b01:   exp_we = 4'b0010;
              2'b10:   exp_we = 4'b0100;
              default: exp_we = 4'b1000;
            endcase
            exp_data = {4{b[7:0]}};
          end
          2'b01: begin
            exp_we = (ea[1:0] == 2'b00) ? 4'b0011 : 4'b1100;
            exp_data = {2{b[15:0]}};
          end
          default: begin
            exp_we = 4'b1111;
            exp_data = b;
          end
        endcase
        if (mis) begin
          exp_we = 4'b0000;
        end
        check_value("addr_to_dmem", {ea[31:2], 2'b00}, addr);
      end
      rv_pkg::op_reg_imm: begin
        result = alu_model(f3, f3 == rv_pkg::f3_sr && insn[30], a, imm_i);
        write_rd = 1'b1;
      end
      rv_pkg::op_reg_reg: begin
        result = alu_model(f3, insn[30], a, b);
        write_rd = 1'b1;
      end
      default: begin
      end
    endcase
    check_value("store_we_to_dmem", {28'd0, exp_we}, {28'd0, store_we});
    if (exp_we != 4'b0000) begin
      mask = {{8{exp_we[3]}}, {8{exp_we[2]}}, {8{exp_we[1]}}, {8{exp_we[0]}}};
      check_value("store_data_to_dmem", exp_data & mask, store_data & mask);
    end
    if (write_rd && rd != 5'd0) begin
      regs[rd] = result;
    end
    model_pc = next_pc;
  endtask

  initial begin
    error_count = 0;
    check_count = 0;
    model_pc = '0;
    for (int i = 0; i < 32; i++) begin
      regs[i] = '0;
    end
    forever begin
      @(posedge clk);
      #8;
      if (rst) begin
        check_value("pc_to_imem", '0, pc);
        check_value("store_we_to_dmem", '0, {28'd0, store_we});
        check_value("halt", '0, {31'd0, halt});
        model_pc = '0;
        for (int i = 0; i < 32; i++) begin
          regs[i] = '0;
        end
      end else begin
        execute_and_compare();
      end
    end
  end

endmodule

/* dv/tb_top.sv */
`timescale 1ns/100ps

module tb_top;

  localparam int period_ns    = 10;
  localparam int reset_cycles = 3;
  localparam int n_insn       = 2000;
  localparam int timeout_ns   = (n_insn + 20) * period_ns;
  localparam logic [31:0] ecall_insn = 32'h0000_0073;
  localparam logic [31:0] nop_insn   = 32'h0000_0013;
  // sw x0, 0(x0)
  localparam logic [31:0] store_insn = 32'h0000_2023;

  logic          clk;
  logic          rst;
  rv_pkg::word_t insn;
  rv_pkg::word_t load_data;
  rv_pkg::word_t pc;
  rv_pkg::word_t addr;
  rv_pkg::word_t store_data;
  logic [3:0]    store_we;
  logic          halt;
  int            error_count;
  int            check_count;
  int unsigned   seed_ret;

  tb_clock #(
    .period_ns    (period_ns),
    .reset_cycles (reset_cycles)
  ) u_clock (
    .clk (clk),
    .rst (rst)
  );

  rv_core i_dut (
    .clk                (clk),
    .rst                (rst),
    .insn_from_imem     (insn),
    .load_data_from_dmem(load_data),
    .pc_to_imem         (pc),
    .addr_to_dmem       (addr),
    .store_data_to_dmem (store_data),
    .store_we_to_dmem   (store_we),
    .halt               (halt)
  );

  tb_checker u_checker (
    .clk         (clk),
    .rst         (rst),
    .insn        (insn),
    .load_data   (load_data),
    .pc          (pc),
    .addr        (addr),
    .store_data  (store_data),
    .store_we    (store_we),
    .halt        (halt),
    .error_count (error_count),
    .check_count (check_count)
  );

  // legal instruction from the kept set, ecall excluded
  function automatic rv_pkg::word_t random_insn();
    logic [31:0] r;
    logic [2:0]  f3;
    int unsigned kind;
    r = $urandom;
    kind = $urandom_range(11, 0);
    f3 = r[14:12];
    case (kind)
      0: r[6:0] = rv_pkg::op_lui;
      1: r[6:0] = rv_pkg::op_auipc;
      2: r[6:0] = rv_pkg::op_jal;
      3: begin
        r[6:0] = rv_pkg::op_jalr;
        r[14:12] = 3'b000;
      end
      4: begin
        r[6:0] = rv_pkg::op_branch;
        // fold 010 and 011 onto beq and bne
        if (f3 == 3'b010 || f3 == 3'b011) begin
          r[13] = 1'b0;
        end
      end
      5, 6: begin
        r[6:0] = rv_pkg::op_load;
        if (f3 == 3'b011) begin
          r[12] = 1'b0;
        end else if (f3[2:1] == 2'b11) begin
          r[13] = 1'b0;
        end
      end
      7, 8: begin
        r[6:0] = rv_pkg::op_store;
        r[14] = 1'b0;
        if (r[13:12] == 2'b11) begin
          r[12] = 1'b0;
        end
      end
      9, 10: begin
        r[6:0] = rv_pkg::op_reg_imm;
        if (f3 == rv_pkg::f3_sll) begin
          r[31:25] = rv_pkg::f7_base;
        end else if (f3 == rv_pkg::f3_sr) begin
          r[31:25] = r[31] ? rv_pkg::f7_alt : rv_pkg::f7_base;
        end
      end
      default: begin
        r[6:0] = rv_pkg::op_reg_reg;
        if ((f3 == rv_pkg::f3_add || f3 == rv_pkg::f3_sr) && r[31]) begin
          r[31:25] = rv_pkg::f7_alt;
        end else begin
          r[31:25] = rv_pkg::f7_base;
        end
      end
    endcase
    return r;
  endfunction

  task automatic drive_random();
    insn = random_insn();
    load_data = $urandom;
  endtask

  initial begin
    seed_ret = $urandom(32'haa4b_7d12);
    insn = nop_insn;
    load_data = '0;
    // words presented during reset must be ignored
    // ecall and an aligned store that reset has to mask
    for (int i = 0; i < reset_cycles - 1; i++) begin
      @(posedge clk);
      #1;
      insn = (i % 2 == 0) ? ecall_insn : store_insn;
      load_data = $urandom;
    end
    repeat (n_insn) begin
      @(posedge clk);
      #1;
      drive_random();
    end
    @(posedge clk);
    #1;
    insn = ecall_insn;
    load_data = $urandom;
    // one more cycle to see pc step past ecall with halt low
    @(posedge clk);
    #1;
    insn = nop_insn;
    #8;
    $display("errors: %0d, checks: %0d", error_count, check_count);
    if (error_count == 0 && check_count > 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

  initial begin
    #(timeout_ns);
    $display("watchdog: stimulus did not complete within %0d ns", timeout_ns);
    $display("Result: FAILED");
    $finish;
  end

endmodule

/* filelist.f */
src/rv_pkg.sv
src/rv_ctrl_if.sv
src/rv_decode.sv
src/rv_regfile.sv
src/rv_alu.sv
src/rv_lsu.sv
src/rv_fetch.sv
src/rv_core.sv
dv/tb_clock.sv
dv/tb_checker.sv
dv/tb_top.sv

/* run.sh */
#!/bin/sh
# build and run the rv32i core testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/100ps \
  --top-module tb_top -f filelist.f -o tb_top_sim
status=$?
if [ "$status" -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit 1
fi

output=$(./obj_dir/tb_top_sim 2>&1)
status=$?
printf '%s\n' "$output"
if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$output" | grep -qx 'Result: PASSED'; then
  exit 0
fi
exit 1
